//--- sd_tx_frame.f
rtl/sd_bus_pkg.sv
rtl/sd_crc_pkg.sv
rtl/sd_word_if.sv
rtl/sd_tx_packetizer.sv
rtl/sd_tx_crc_bank.sv
rtl/sd_tx_serializer.sv
rtl/sd_tx_frame.sv
test/sd_tx_frame_asserts.sv
test/tb_sd_tx_frame.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_sd_tx_frame
FILELIST ?= sd_tx_frame.f
BUILD_DIR ?= obj_dir
LINT_FLAGS ?= -Wall --timing
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
RUN_FLAGS ?= +verilator+error+limit+100
PASS_TEXT ?= TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS)); echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- test/tb_sd_tx_frame.sv
`timescale 1ns/100ps
`default_nettype none

module tb_sd_tx_frame;
	import sd_bus_pkg::*;

	localparam int N_TESTS = 7;
	localparam int SEED = 94767;

	typedef struct packed {
		bus_width_t width;
		int nwords;
		int period;
		logic rand_data;
		logic [3:0][WORD_W-1:0] data;
	} test_t;

	logic i_clk;
	logic i_reset;
	bus_width_t i_cfg_width;
	logic i_en;
	logic i_ckstb;
	logic i_s_valid;
	word_t i_s_data;
	logic i_s_last;
	logic o_s_ready;
	logic o_tx_valid;
	symbol_t o_tx_data;

	test_t tests [N_TESTS];
	symbol_t expected_q [$];
	int errors = 0;
	int cycle_count = 0;
	int timeout_limit = 0;
	int assert_errors;

	initial i_clk = 1'b0;
	always #10 i_clk = ~i_clk;

	sd_tx_frame DUT (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_cfg_width(i_cfg_width),
		.i_en(i_en),
		.i_ckstb(i_ckstb),
		.i_s_valid(i_s_valid),
		.i_s_data(i_s_data),
		.i_s_last(i_s_last),
		.o_s_ready(o_s_ready),
		.o_tx_valid(o_tx_valid),
		.o_tx_data(o_tx_data)
	);

	bind sd_tx_frame sd_tx_frame_asserts u_asserts (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_ckstb(i_ckstb),
		.i_width(width),
		.i_tx_valid(o_tx_valid),
		.i_tx_data(o_tx_data)
	);

	always @(posedge i_clk) begin
		cycle_count++;
		if (cycle_count > timeout_limit) begin
			$display("timeout: run did not finish within %0d cycles", timeout_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////
	task automatic check_symbol(symbol_t got, symbol_t exp, string what);
		if (got !== exp) begin
			errors++;
			$display("error at %0d ns: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_valid(bit got, bit exp, string what);
		if (got != exp) begin
			errors++;
			$display("error at %0d ns: %s got %0b, expected %0b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(int got, int exp, string what);
		if (got != exp) begin
			errors++;
			$display("error at %0d ns: %s got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	function automatic int wire_count(bus_width_t width);
		case (width)
			W4: return 4;
			W8: return 8;
			default: return 1;
		endcase
	endfunction

	// Same byte on all four lanes with unused wires high
	function automatic symbol_t wire_symbol(logic [7:0] wires, int nw);
		logic [7:0] b;
		b = 8'hFF;
		for (int i = 0; i < nw; i++)
			b[i] = wires[i];
		return {4{b}};
	endfunction

	function automatic logic [15:0] crc16_bit(logic [15:0] crc, logic din);
		logic fb;
		fb = din ^ crc[15];
		crc16_bit = {crc[14:0], 1'b0};
		if (fb)
			crc16_bit = crc16_bit ^ 16'h1021;
	endfunction

	task automatic build_expected(bus_width_t width, int nwords,
		logic [3:0][WORD_W-1:0] words);
		int nw;
		logic [15:0] crc [8];
		logic [7:0] wires;
		nw = wire_count(width);
		for (int i = 0; i < 8; i++)
			crc[i] = '0;
		expected_q.delete();
		expected_q.push_back(wire_symbol(8'h00, nw));
		for (int w = 0; w < nwords; w++) begin
			for (int k = 0; k < WORD_W / nw; k++) begin
				wires = '0;
				// Highest wire takes the word's MSB
				for (int i = 0; i < nw; i++) begin
					wires[i] = words[w][WORD_W - nw * (k + 1) + i];
					crc[i] = crc16_bit(crc[i], wires[i]);
				end
				expected_q.push_back(wire_symbol(wires, nw));
			end
		end
		for (int k = 15; k >= 0; k--) begin
			wires = '0;
			for (int i = 0; i < nw; i++)
				wires[i] = crc[i][k];
			expected_q.push_back(wire_symbol(wires, nw));
		end
		expected_q.push_back(32'hFFFF_FFFF);
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus table with word 0 last in each data field
	////////////////////////////////////////////////////////////
	task automatic load_tests();
		tests[0] = '{W1, 1, 1, 1'b0, {32'h0, 32'h0, 32'h0, 32'hA5C3_0F81}};
		tests[1] = '{W4, 3, 1, 1'b0, {32'h0, 32'h0F0F_F0F0, 32'h9ABC_DEF0, 32'h1234_5678}};
		tests[2] = '{W8, 2, 1, 1'b0, {32'h0, 32'h0, 32'h0000_FFFF, 32'hDEAD_BEEF}};
		tests[3] = '{W4, 4, 3, 1'b1, '0};
		tests[4] = '{W1, 2, 2, 1'b1, '0};
		tests[5] = '{W8, 4, 3, 1'b1, '0};
		tests[6] = '{W4, 1, 2, 1'b0, {32'h0, 32'h0, 32'h0, 32'hFFFF_0000}};
	endtask

	function automatic int total_symbols();
		int sum;
		sum = 0;
		for (int i = 0; i < N_TESTS; i++)
			sum += 2 + tests[i].nwords * (WORD_W / wire_count(tests[i].width)) + 16;
		return sum;
	endfunction

	task automatic run_test(int idx);
		test_t t;
		logic [3:0][WORD_W-1:0] words;
		int spw;
		int phase;
		int n_sent;
		int n_seen;
		logic prev_valid;
		logic prev_strobe;
		logic done;
		logic accepted;
		symbol_t last_sym;
		t = tests[idx];
		words = t.data;
		if (t.rand_data) begin
			for (int w = 0; w < 4; w++)
				words[w] = $urandom;
		end
		spw = WORD_W / wire_count(t.width);
		build_expected(t.width, t.nwords, words);
		// New width while the framer is disabled so the CRCs clear
		@(posedge i_clk);
		#1;
		i_cfg_width = t.width;
		i_en = 1'b0;
		i_ckstb = 1'b0;
		i_s_valid = 1'b0;
		repeat (2) @(posedge i_clk);
		#1;
		i_en = 1'b1;
		i_s_valid = 1'b1;
		i_s_data = words[0];
		i_s_last = (t.nwords == 1);
		phase = 0;
		n_sent = 0;
		n_seen = 0;
		prev_valid = 1'b0;
		prev_strobe = 1'b0;
		done = 1'b0;
		last_sym = '1;
		while (!done) begin
			i_ckstb = (phase == 0);
			phase = (phase + 1) % t.period;
			@(negedge i_clk);
			// New symbol after a strobe or the start symbol
			if (o_tx_valid && (!prev_valid || prev_strobe)) begin
				if (n_seen < expected_q.size())
					check_symbol(o_tx_data, expected_q[n_seen], "tx symbol");
				else begin
					errors++;
					$display("error at %0d ns: symbol %0d beyond the packet", $time, n_seen);
				end
				last_sym = o_tx_data;
				n_seen++;
			end else if (o_tx_valid) begin
				check_symbol(o_tx_data, last_sym, "held symbol");
			end
			done = prev_valid && !o_tx_valid;
			if (done)
				check_symbol(o_tx_data, 32'hFFFF_FFFF, "idle output");
			accepted = o_s_ready && i_s_valid;
			if (o_s_ready) begin
				check_valid(i_ckstb, 1'b1, "strobe with ready");
				check_count(n_seen, (n_sent == 0) ? 0 : 1 + (n_sent - 1) * spw,
					"symbols before word accept");
			end
			prev_valid = o_tx_valid;
			prev_strobe = i_ckstb;
			@(posedge i_clk);
			#1;
			if (accepted) begin
				n_sent++;
				if (n_sent < t.nwords) begin
					i_s_data = words[n_sent];
					i_s_last = (n_sent == t.nwords - 1);
				end else begin
					i_s_valid = 1'b0;
					i_s_last = 1'b0;
				end
			end
		end
		i_en = 1'b0;
		i_ckstb = 1'b0;
		check_count(n_seen, expected_q.size(), "symbols per packet");
		check_count(n_sent, t.nwords, "accepted words");
	endtask

	initial begin
		void'($urandom(SEED));
		load_tests();
		timeout_limit = 4 * total_symbols() + 200;
		i_reset = 1'b0;
		i_cfg_width = W1;
		i_en = 1'b0;
		i_ckstb = 1'b0;
		i_s_valid = 1'b0;
		i_s_data = '0;
		i_s_last = 1'b0;
		repeat (5) @(posedge i_clk);
		#1;
		i_reset = 1'b1;
		@(negedge i_clk);
		check_valid(o_tx_valid, 1'b0, "tx valid after reset");
		check_valid(o_s_ready, 1'b0, "stream ready after reset");
		check_symbol(o_tx_data, 32'hFFFF_FFFF, "tx data after reset");
		for (int i = 0; i < N_TESTS; i++)
			run_test(i);
		assert_errors = DUT.u_asserts.fail_count;
		$display("errors: %0d check, %0d assertion", errors, assert_errors);
		if ((errors == 0) && (assert_errors == 0)) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- test/sd_tx_frame_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module sd_tx_frame_asserts (
	input wire logic i_clk,
	input wire logic i_reset,
	input wire logic i_ckstb,
	input wire sd_bus_pkg::bus_width_t i_width,
	input wire logic i_tx_valid,
	input wire sd_bus_pkg::symbol_t i_tx_data
);
	import sd_bus_pkg::*;

	int fail_count = 0;
	logic [7:0] used;

	// Wires in use for the current width
	always_comb begin
		case (i_width)
			W4: used = 8'h0F;
			W8: used = 8'hFF;
			default: used = 8'h01;
		endcase
	end

	a_idle_after_reset: assert property (@(posedge i_clk) !i_reset |=> !i_tx_valid)
		else begin
			fail_count++;
			$error("tx valid high in the cycle after reset");
		end

	a_unused_high: assert property (@(posedge i_clk) disable iff (!i_reset)
		((i_tx_data | {4{used}}) == 32'hFFFF_FFFF))
		else begin
			fail_count++;
			$error("unused wire bit low in tx data %h", i_tx_data);
		end

	// All four byte lanes carry the same wires
	a_bytes_equal: assert property (@(posedge i_clk) disable iff (!i_reset)
		((i_tx_data[31:24] == i_tx_data[7:0]) && (i_tx_data[23:16] == i_tx_data[7:0])
		&& (i_tx_data[15:8] == i_tx_data[7:0])))
		else begin
			fail_count++;
			$error("tx data byte lanes differ: %h", i_tx_data);
		end

	a_change_on_strobe: assert property (@(posedge i_clk) disable iff (!i_reset)
		!$stable(i_tx_data) |-> $past(i_ckstb))
		else begin
			fail_count++;
			$error("tx data changed without a strobe");
		end

endmodule

`default_nettype wire

//--- rtl/sd_tx_frame.sv
`timescale 1ns/100ps
`default_nettype none

module sd_tx_frame #(
	parameter int NCRC = sd_crc_pkg::CRC_W,
	parameter logic [NCRC-1:0] CRC_POLYNOMIAL = sd_crc_pkg::CRC_POLY
) (
	input wire logic i_clk,
	input wire logic i_reset,
	input wire sd_bus_pkg::bus_width_t i_cfg_width,
	input wire logic i_en,
	input wire logic i_ckstb,
	input wire logic i_s_valid,
	input wire sd_bus_pkg::word_t i_s_data,
	input wire logic i_s_last,
	output logic o_s_ready,
	output logic o_tx_valid,
	output sd_bus_pkg::symbol_t o_tx_data
);
	import sd_bus_pkg::*;

	bus_width_t width;
	logic crc_clear;
	logic crc_advance;
	logic crc_shift;
	word_t crc_word;

	sd_word_if word_bus ();

	////////////////////////////////////////////////////////////
	// Packetizer, CRC bank, serializer
	////////////////////////////////////////////////////////////
	sd_tx_packetizer #(
		.NCRC(NCRC)
	) u_packetizer (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_cfg_width(i_cfg_width),
		.i_en(i_en),
		.i_ckstb(i_ckstb),
		.i_s_valid(i_s_valid),
		.i_s_data(i_s_data),
		.i_s_last(i_s_last),
		.o_s_ready(o_s_ready),
		.o_width(width),
		.o_crc_clear(crc_clear),
		.o_crc_advance(crc_advance),
		.o_crc_shift(crc_shift),
		.i_crc_word(crc_word),
		.word_bus(word_bus.packetizer)
	);

	sd_tx_crc_bank #(
		.NCRC(NCRC),
		.CRC_POLYNOMIAL(CRC_POLYNOMIAL)
	) u_crc_bank (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_width(width),
		.i_clear(crc_clear),
		.i_advance(crc_advance),
		.i_data(i_s_data),
		.i_shift(crc_shift),
		.o_crc_word(crc_word)
	);

	sd_tx_serializer #(
		.NCRC(NCRC)
	) u_serializer (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_width(width),
		.i_ckstb(i_ckstb),
		.word_bus(word_bus.serializer),
		.o_tx_valid(o_tx_valid),
		.o_tx_data(o_tx_data)
	);

endmodule

`default_nettype wire

//--- rtl/sd_tx_serializer.sv
`timescale 1ns/100ps
`default_nettype none

module sd_tx_serializer #(
	parameter int NCRC = sd_crc_pkg::CRC_W
) (
	input wire logic i_clk,
	input wire logic i_reset,
	input wire sd_bus_pkg::bus_width_t i_width,
	input wire logic i_ckstb,
	sd_word_if.serializer word_bus,
	output logic o_tx_valid,
	output sd_bus_pkg::symbol_t o_tx_data
);
	import sd_bus_pkg::*;

	word_t sreg;
	word_t fill;
	logic [4:0] count;
	logic [4:0] load_count;
	logic stop_pending;
	int unsigned nw;

	assign nw = bus_wires(i_width);

	// Ones shifted in behind the data
	assign fill = ~({WORD_W{1'b1}} << nw);

	// Symbols per word minus one, short word for the 1-wire CRC
	assign load_count = 5'((word_bus.short_word ? NCRC : WORD_W) / nw - 1);

	assign word_bus.ready = i_ckstb && (count == '0);
	assign word_bus.busy = o_tx_valid;

	////////////////////////////////////////////////////////////
	// Symbol output and countdown
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk) begin
		if (!i_reset) begin
			o_tx_valid <= 1'b0;
			o_tx_data <= '1;
			count <= '0;
			stop_pending <= 1'b0;
		end else if (word_bus.start) begin
			// Start symbol, used wires low
			o_tx_valid <= 1'b1;
			o_tx_data <= make_symbol('0, i_width);
			stop_pending <= 1'b1;
		end else if (word_bus.ready) begin
			o_tx_valid <= word_bus.valid || stop_pending;
			stop_pending <= word_bus.valid;
			if (word_bus.valid) begin
				o_tx_data <= make_symbol(word_bus.data, i_width);
				count <= load_count;
			end else begin
				// Stop symbol, or idle
				o_tx_data <= '1;
			end
		end else if (i_ckstb && (count != '0)) begin
			count <= count - 1'b1;
			o_tx_data <= make_symbol(sreg, i_width);
		end
	end

	// Word shift register, MSB first
	always_ff @(posedge i_clk) begin
		if (word_bus.ready && word_bus.valid)
			sreg <= (word_bus.data << nw) | fill;
		else if (i_ckstb && (count != '0))
			sreg <= (sreg << nw) | fill;
	end

endmodule

`default_nettype wire

//--- rtl/sd_tx_crc_bank.sv
`timescale 1ns/100ps
`default_nettype none

module sd_tx_crc_bank #(
	parameter int NCRC = sd_crc_pkg::CRC_W,
	parameter logic [NCRC-1:0] CRC_POLYNOMIAL = sd_crc_pkg::CRC_POLY
) (
	input wire logic i_clk,
	input wire logic i_reset,
	input wire sd_bus_pkg::bus_width_t i_width,
	input wire logic i_clear,
	input wire logic i_advance,
	input wire sd_bus_pkg::word_t i_data,
	input wire logic i_shift,
	output sd_bus_pkg::word_t o_crc_word
);
	import sd_bus_pkg::*;
	import sd_crc_pkg::*;

	localparam int NLANE = 8;
	localparam int BANK_W = NLANE * NCRC;

	// Used lanes sit at the top, CRC bit b of wire w at base + b*nw + w
	logic [BANK_W-1:0] bank;
	logic [BANK_W-1:0] bank_next;
	logic [BANK_W+WORD_W-1:0] bank_shifted;

	always_comb begin
		int unsigned nw;
		int unsigned nbits;
		int unsigned base;
		logic [NCRC-1:0] lane;
		crc_acc_t lane_bits;
		crc_acc_t lane_new;

		nw = bus_wires(i_width);
		nbits = WORD_W / nw;
		base = BANK_W - nw * NCRC;
		// Bits below the used lanes pad the last CRC word with ones
		bank_next = '1;
		for (int w = 0; w < NLANE; w++) begin
			lane = '0;
			lane_bits = '0;
			for (int b = 0; b < NCRC; b++) begin
				if (w < nw)
					lane[b] = bank[base + b * nw + w];
			end
			// This wire's bits of the word, earliest in the top slot
			for (int k = 0; k < WORD_W; k++) begin
				if ((k < nbits) && (w < nw))
					lane_bits[nbits - 1 - k] = i_data[WORD_W - nw * (k + 1) + w];
			end
			lane_new = crc_apply(crc_acc_t'(lane), crc_acc_t'(CRC_POLYNOMIAL), NCRC,
				lane_bits, nbits);
			for (int b = 0; b < NCRC; b++) begin
				if (w < nw)
					bank_next[base + b * nw + w] = lane_new[b];
			end
		end
	end

	assign bank_shifted = {bank, {WORD_W{1'b1}}};

	always_ff @(posedge i_clk) begin
		if (!i_reset || i_clear)
			bank <= '0;
		else if (i_advance)
			bank <= bank_next;
		else if (i_shift)
			bank <= bank_shifted[BANK_W-1:0];
	end

	// In 1-wire mode this is the single CRC followed by ones
	assign o_crc_word = bank[BANK_W-1 -: WORD_W];

endmodule

`default_nettype wire

//--- rtl/sd_tx_packetizer.sv
`timescale 1ns/100ps
`default_nettype none

module sd_tx_packetizer #(
	parameter int NCRC = sd_crc_pkg::CRC_W
) (
	input wire logic i_clk,
	input wire logic i_reset,
	input wire sd_bus_pkg::bus_width_t i_cfg_width,
	input wire logic i_en,
	input wire logic i_ckstb,
	input wire logic i_s_valid,
	input wire sd_bus_pkg::word_t i_s_data,
	input wire logic i_s_last,
	output logic o_s_ready,
	output sd_bus_pkg::bus_width_t o_width,
	output logic o_crc_clear,
	output logic o_crc_advance,
	output logic o_crc_shift,
	input wire sd_bus_pkg::word_t i_crc_word,
	sd_word_if.packetizer word_bus
);
	import sd_bus_pkg::*;

	pkt_state_t state;
	bus_width_t cfg_width;
	logic [3:0] crc_left;
	logic [3:0] crc_words_m1;
	logic start;

	// Width follows the config pin until a packet begins
	assign o_width = (state == P_IDLE) ? i_cfg_width : cfg_width;

	assign start = i_en && i_s_valid && i_ckstb && !word_bus.busy && (state == P_IDLE);
	assign word_bus.start = start;

	// First word goes with the start symbol
	assign o_s_ready = (state == P_IDLE) ? start : ((state == P_DATA) && word_bus.ready);

	assign o_crc_advance = i_s_valid && o_s_ready;
	assign o_crc_shift = (state == P_CRC) && word_bus.ready;
	assign o_crc_clear = !i_en && !word_bus.busy;

	// One less than the CRC words per packet (1, 2 or 4 words for NCRC of 16)
	assign crc_words_m1 = 4'((bus_wires(o_width) * NCRC + WORD_W - 1) / WORD_W - 1);

	////////////////////////////////////////////////////////////
	// Packet FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk) begin
		if (!i_reset) begin
			state <= P_IDLE;
			cfg_width <= W1;
			crc_left <= '0;
			word_bus.valid <= 1'b0;
			word_bus.short_word <= 1'b0;
		end else begin
			case (state)
				P_IDLE: begin
					cfg_width <= i_cfg_width;
					crc_left <= crc_words_m1;
					if (start) begin
						word_bus.valid <= 1'b1;
						state <= i_s_last ? P_CRC : P_DATA;
					end
				end
				P_DATA: begin
					// Stream is expected to stay valid inside a frame
					if (o_crc_advance) begin
						word_bus.valid <= 1'b1;
						if (i_s_last)
							state <= P_CRC;
					end else if (word_bus.ready) begin
						word_bus.valid <= 1'b0;
					end
				end
				P_CRC: begin
					if (word_bus.ready) begin
						word_bus.valid <= 1'b1;
						word_bus.short_word <= (cfg_width == W1);
						if (crc_left == '0)
							state <= P_LAST;
						else
							crc_left <= crc_left - 1'b1;
					end
				end
				P_LAST: begin
					if (word_bus.ready) begin
						word_bus.valid <= 1'b0;
						word_bus.short_word <= 1'b0;
					end
					// Stop symbol done
					if (!word_bus.busy)
						state <= P_IDLE;
				end
				default: state <= P_IDLE;
			endcase
		end
	end

	// Pending word from the stream and then from the CRC bank
	always_ff @(posedge i_clk) begin
		if (o_crc_advance)
			word_bus.data <= i_s_data;
		else if (o_crc_shift)
			word_bus.data <= i_crc_word;
	end

endmodule

`default_nettype wire

//--- rtl/sd_word_if.sv
`timescale 1ns/100ps
`default_nettype none

interface sd_word_if;
	import sd_bus_pkg::*;

	logic valid;
	word_t data;
	// 1-wire CRC word, sent as a short run of symbols
	logic short_word;
	logic start;
	logic ready;
	logic busy;

	modport packetizer (output valid, data, short_word, start, input ready, busy);
	modport serializer (input valid, data, short_word, start, output ready, busy);
	modport monitor (input valid, data, short_word, start, ready, busy);

endinterface

`default_nettype wire

//--- rtl/sd_crc_pkg.sv
`default_nettype none

package sd_crc_pkg;

	localparam int CRC_W = 16;
	localparam logic [CRC_W-1:0] CRC_POLY = 16'h1021;

	// Widest CRC, and longest bit run per call
	localparam int CRC_MAX_W = 32;

	typedef logic [CRC_W-1:0] crc_t;
	typedef logic [CRC_MAX_W-1:0] crc_acc_t;

	// One bit into a len-bit CRC held in the low bits of crc
	function automatic crc_acc_t crc_step(crc_acc_t crc, crc_acc_t poly,
		int unsigned len, logic din);
		crc_acc_t mask;
		logic feedback;
		if (len >= CRC_MAX_W)
			mask = '1;
		else
			mask = (crc_acc_t'(1) << len) - 1'b1;
		feedback = din ^ crc[len-1];
		crc_step = (crc << 1) & mask;
		if (feedback)
			crc_step = crc_step ^ (poly & mask);
	endfunction

	// Low nbits of bits, highest first in time
	function automatic crc_acc_t crc_apply(crc_acc_t crc, crc_acc_t poly,
		int unsigned len, crc_acc_t bits, int unsigned nbits);
		crc_acc_t acc;
		acc = crc;
		for (int k = CRC_MAX_W - 1; k >= 0; k--) begin
			if (k < nbits)
				acc = crc_step(acc, poly, len, bits[k]);
		end
		crc_apply = acc;
	endfunction

endpackage

`default_nettype wire

//--- rtl/sd_bus_pkg.sv
`default_nettype none

package sd_bus_pkg;

	localparam int WORD_W = 32;

	typedef enum logic [1:0] {
		W1 = 2'd0,
		W4 = 2'd1,
		W8 = 2'd2
	} bus_width_t;

	typedef enum logic [1:0] {
		P_IDLE,
		P_DATA,
		P_CRC,
		P_LAST
	} pkt_state_t;

	typedef logic [WORD_W-1:0] word_t;

	// Four copies of one wire byte, unused wires held high
	typedef logic [31:0] symbol_t;

	// Number of data wires in use
	function automatic int unsigned bus_wires(bus_width_t width);
		case (width)
			W4: bus_wires = 4;
			W8: bus_wires = 8;
			default: bus_wires = 1;
		endcase
	endfunction

	// Top bits of a word onto the used wires, wire 0 in bit 0
	function automatic symbol_t make_symbol(word_t w, bus_width_t width);
		logic [7:0] wire_byte;
		int unsigned nw;
		nw = bus_wires(width);
		wire_byte = '1;
		for (int i = 0; i < 8; i++) begin
			if (i < nw)
				wire_byte[i] = w[WORD_W - nw + i];
		end
		make_symbol = {4{wire_byte}};
	endfunction

endpackage

`default_nettype wire
